// ==== flist.f ====
+incdir+source
source/uart_pkg.sv
source/uart_rx.sv
source/byte_fifo.sv
source/uart_tx.sv
source/uart_echo_top.sv
sim/uart_echo_assertions.sv
sim/uart_echo_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the UART echo testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f flist.f --top-module uart_echo_tb -Mdir obj_dir -o uart_echo_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/uart_echo_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
fi
exit $status

// ==== sim/uart_echo_tb.sv ====
// UART echo testbench: serial stimulus, echo decoder and reference checks
`include "uart_settings.svh"

module uart_echo_tb;

  localparam int BIT_CLKS = `UART_CLKS_PER_BIT;
  // Longest wait for any DUT event, in clocks
  localparam int WAIT_LIMIT = 24 * BIT_CLKS;

  logic clk = 1'b0;
  logic i_rst;
  logic i_rx;
  logic o_tx;
  logic o_drop;

  uart_pkg::rx_word_t exp_q[$];
  int unsigned exp_drops = 0;
  int unsigned seen_drops = 0;
  logic [31:0] lcg_state = 32'd30;

  uart_echo_top dut0 (
    .clk    (clk),
    .i_rst  (i_rst),
    .i_rx   (i_rx),
    .o_tx   (o_tx),
    .o_drop (o_drop)
  );

  always #20 clk = ~clk;

  // ==========================================================================
  // Reference model and checks
  // ==========================================================================
  // Good frames come back unchanged, a low stop bit marks the word bad
  function automatic uart_pkg::rx_word_t ref_echo(input logic [7:0] data,
                                                  input logic bad_stop);
    uart_pkg::rx_word_t w;
    w.data      = data;
    w.frame_err = bad_stop;
    return w;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_word(input uart_pkg::rx_word_t got, input uart_pkg::rx_word_t exp);
    if (got !== exp) begin
      $display("[FAIL] o_tx word: got 0x%h expected 0x%h", got, exp);
      stop_run();
    end
  endtask

  task automatic check_drop(input int unsigned got, input int unsigned exp);
    if (got != exp) begin
      $display("[FAIL] o_drop count: got 0x%h expected 0x%h", got, exp);
      stop_run();
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  // ==========================================================================
  // Serial stimulus
  // ==========================================================================
  task automatic drive_bit(input logic b);
    @(negedge clk);
    i_rx = b;
    repeat (BIT_CLKS - 1) @(negedge clk);
  endtask

  // LSB first, an idle bit follows a bad stop so the next start edge is seen
  task automatic send_frame(input logic [7:0] data, input logic bad_stop);
    uart_pkg::rx_word_t w;
    w = ref_echo(data, bad_stop);
    if (w.frame_err) begin
      exp_drops++;
    end else begin
      exp_q.push_back(w);
    end
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(data[i]);
    end
    drive_bit(~bad_stop);
    if (bad_stop) begin
      drive_bit(1'b1);
    end
  endtask

  task automatic check_quiet(input int clocks);
    repeat (clocks) begin
      @(negedge clk);
      check_level("o_tx", o_tx, 1'b1);
      check_level("o_drop", o_drop, 1'b0);
    end
  endtask

  // All echoes decoded and all drops seen, then the line must stay quiet
  task automatic finish_step();
    int n;
    n = 0;
    while (exp_q.size() != 0 || seen_drops < exp_drops) begin
      if (n == WAIT_LIMIT) begin
        $display("Timeout: echoes or drops still missing after %0d clocks", n);
        stop_run();
      end
      n++;
      @(negedge clk);
    end
    check_quiet(2 * BIT_CLKS);
    check_drop(seen_drops, exp_drops);
  endtask

  always @(negedge clk) begin
    if (o_drop === 1'b1) begin
      seen_drops++;
    end
  end

  // Echo decoder, samples o_tx at mid-bit
  initial begin : decoder
    uart_pkg::rx_word_t got;
    int n;
    forever begin
      n = 0;
      @(negedge clk);
      while (o_tx !== 1'b0) begin
        if (exp_q.size() != 0) begin
          n++;
        end
        if (n == WAIT_LIMIT) begin
          $display("Timeout: an expected echo frame never started on o_tx");
          stop_run();
        end
        @(negedge clk);
      end
      repeat (BIT_CLKS / 2) @(negedge clk);
      check_level("o_tx start bit", o_tx, 1'b0);
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CLKS) @(negedge clk);
        got.data[i] = o_tx;
      end
      repeat (BIT_CLKS) @(negedge clk);
      got.frame_err = ~o_tx;
      if (exp_q.size() == 0) begin
        $display("Echo frame with data 0x%h arrived with no byte pending", got.data);
        stop_run();
      end else begin
        check_word(got, exp_q.pop_front());
      end
    end
  end

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin : stimulus
    i_rst = 1'b1;
    i_rx  = 1'b1;
    repeat (10) @(negedge clk);
    i_rst = 1'b0;

    check_quiet(4 * BIT_CLKS);
    check_drop(seen_drops, 0);

    send_frame(8'hA5, 1'b0);
    finish_step();

    // Twenty random bytes back to back
    repeat (20) begin
      lcg_state = lcg_next(lcg_state);
      send_frame(lcg_state[23:16], 1'b0);
    end
    finish_step();

    // Bad stop bit, then a good byte
    send_frame(8'h3C, 1'b1);
    send_frame(8'h5A, 1'b0);
    finish_step();

    // Mixed burst, some bad frames forced
    for (int i = 0; i < 16; i++) begin
      lcg_state = lcg_next(lcg_state);
      send_frame(lcg_state[23:16], (i % 5 == 2) || (lcg_state[29:28] == 2'b00));
    end
    finish_step();

    if (exp_q.size() == 0 && seen_drops == exp_drops) begin
      $display("All tests passed");
      $finish;
    end else begin
      stop_run();
    end
  end

endmodule

// ==== sim/uart_echo_assertions.sv ====
// UART echo protocol assertions on the top level and its FIFO handshake
`include "uart_settings.svh"

module uart_echo_assertions (
  input logic                 clk,
  input logic                 i_rst,
  input logic                 i_tx,
  input logic                 i_drop,
  input logic                 i_pop,
  input logic                 i_empty,
  input logic                 i_wr,
  input uart_pkg::tx_state_e  i_tx_state
);

  localparam int AW = `UART_FIFO_DEPTH_LOG2;
  localparam int OW = AW + 1;

  // Shadow occupancy count, full when the top bit is set
  logic [AW:0] occ;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      occ <= '0;
    end else begin
      occ <= occ + OW'(i_wr) - OW'(i_pop);
    end
  end

  // ==========================================================================
  // Properties
  // ==========================================================================
  a_idle_line_high: assert property (@(posedge clk) disable iff (i_rst)
    (i_tx_state == uart_pkg::TX_IDLE) |-> i_tx)
    else $error("o_tx low while the transmitter is idle");

  // Shadow count says nothing is stored
  a_no_pop_when_empty: assert property (@(posedge clk) disable iff (i_rst)
    (occ == '0) |-> (i_empty && !i_pop))
    else $error("pop issued while the FIFO is empty");

  a_no_write_when_full: assert property (@(posedge clk) disable iff (i_rst)
    i_wr |-> !occ[AW])
    else $error("receiver wrote into a full FIFO");

  a_drop_one_clock: assert property (@(posedge clk) disable iff (i_rst)
    i_drop |=> !i_drop)
    else $error("o_drop held high for more than one clock");

endmodule

bind uart_echo_top uart_echo_assertions asrt0 (
  .clk        (clk),
  .i_rst      (i_rst),
  .i_tx       (o_tx),
  .i_drop     (o_drop),
  .i_pop      (pop),
  .i_empty    (empty),
  .i_wr       (rx_valid),
  .i_tx_state (tx0.state)
);

// ==== source/uart_echo_top.sv ====
// UART echo path: receiver into word FIFO into transmitter
module uart_echo_top (
  input  logic clk,
  input  logic i_rst,
  input  logic i_rx,
  output logic o_tx,
  output logic o_drop
);

  // Receiver to FIFO
  uart_pkg::rx_word_t rx_word;
  logic               rx_valid;

  // FIFO to transmitter
  uart_pkg::rx_word_t head;
  logic               empty;
  logic               pop;

  // ==========================================================================
  // Datapath
  // ==========================================================================
  uart_rx rx0 (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_rx    (i_rx),
    .o_word  (rx_word),
    .o_valid (rx_valid)
  );

  byte_fifo fifo0 (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_wr    (rx_valid),
    .i_word  (rx_word),
    .i_pop   (pop),
    .o_head  (head),
    .o_empty (empty)
  );

  // Bad frames are discarded here, never echoed
  uart_tx tx0 (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_head  (head),
    .i_empty (empty),
    .o_pop   (pop),
    .o_tx    (o_tx),
    .o_drop  (o_drop)
  );

endmodule

// ==== source/uart_tx.sv ====
// UART 8N1 transmitter: pops received words, drops bad ones, sends good ones
`include "uart_settings.svh"

module uart_tx (
  input  logic                clk,
  input  logic                i_rst,
  input  uart_pkg::rx_word_t  i_head,
  input  logic                i_empty,
  output logic                o_pop,
  output logic                o_tx,
  output logic                o_drop
);

  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT + 1);

  uart_pkg::tx_state_e state;
  logic [CNT_W-1:0]    cnt;
  logic [2:0]          bit_idx;
  logic [7:0]          shift;
  logic                tx_q;
  logic                drop_q;
  logic                bit_done;
  logic                ready;

  assign bit_done = (cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));

  // Idle, or the last clock of a stop bit, can take the next word
  assign ready  = (state == uart_pkg::TX_IDLE) ||
                  ((state == uart_pkg::TX_STOP) && bit_done);
  // Hold off one clock after a drop so the drop pulse stays single
  assign o_pop  = ready && !i_empty && !drop_q;
  assign o_tx   = tx_q;
  assign o_drop = drop_q;

  // ==========================================================================
  // Frame FSM
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (i_rst) begin
      state   <= uart_pkg::TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      tx_q    <= 1'b1;
      drop_q  <= 1'b0;
    end else begin
      drop_q <= 1'b0;
      cnt    <= bit_done ? '0 : cnt + 1'b1;
      case (state)
        uart_pkg::TX_IDLE: begin
          cnt  <= '0;
          tx_q <= 1'b1;
        end
        uart_pkg::TX_START: begin
          if (bit_done) begin
            state   <= uart_pkg::TX_DATA;
            bit_idx <= '0;
            tx_q    <= shift[0];
          end
        end
        uart_pkg::TX_DATA: begin
          if (bit_done) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= uart_pkg::TX_STOP;
              tx_q  <= 1'b1;
            end else begin
              tx_q <= shift[0];
            end
          end
        end
        default: begin
          if (bit_done) begin
            state <= uart_pkg::TX_IDLE;
          end
        end
      endcase
      // Taking a word overrides the idle return above
      if (o_pop) begin
        if (i_head.frame_err) begin
          drop_q <= 1'b1;
        end else begin
          state <= uart_pkg::TX_START;
          cnt   <= '0;
          tx_q  <= 1'b0;
        end
      end
    end
  end

  // Data shifts out LSB first
  always_ff @(posedge clk) begin
    if (o_pop && !i_head.frame_err) begin
      shift <= i_head.data;
    end else if (bit_done && ((state == uart_pkg::TX_START) ||
                              (state == uart_pkg::TX_DATA))) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

endmodule

// ==== source/byte_fifo.sv ====
// Received-word FIFO, first word falls through to the head output
`include "uart_settings.svh"

module byte_fifo (
  input  logic                clk,
  input  logic                i_rst,
  input  logic                i_wr,
  input  uart_pkg::rx_word_t  i_word,
  input  logic                i_pop,
  output uart_pkg::rx_word_t  o_head,
  output logic                o_empty
);

  localparam int AW    = `UART_FIFO_DEPTH_LOG2;
  localparam int DEPTH = 1 << AW;

  uart_pkg::rx_word_t mem [DEPTH];

  // Pointers carry one wrap bit above the index
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic [AW:0] used;
  logic        full;

  assign used    = wr_ptr - rd_ptr;
  assign full    = used[AW];
  assign o_empty = (used == '0);
  assign o_head  = mem[rd_ptr[AW-1:0]];

  // ==========================================================================
  // Pointer update
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      // Write into a full FIFO is dropped
      if (i_wr && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_pop && !o_empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (i_wr && !full) begin
      mem[wr_ptr[AW-1:0]] <= i_word;
    end
  end

endmodule

// ==== source/uart_rx.sv ====
// UART 8N1 receiver: samples i_rx at mid-bit and emits one word per frame
`include "uart_settings.svh"

module uart_rx (
  input  logic                clk,
  input  logic                i_rst,
  input  logic                i_rx,
  output uart_pkg::rx_word_t  o_word,
  output logic                o_valid
);

  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT + 1);

  uart_pkg::rx_state_e state;
  logic [CNT_W-1:0]    cnt;
  logic [2:0]          bit_idx;
  logic [7:0]          shift;
  logic                rx_meta;
  logic                rx_s;
  logic                rx_prev;
  logic                half_done;
  logic                bit_done;
  logic                stop_sample;

  assign half_done   = (cnt == CNT_W'(`UART_CLKS_PER_BIT / 2 - 1));
  assign bit_done    = (cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));
  assign stop_sample = (state == uart_pkg::RX_STOP) && bit_done;

  // ==========================================================================
  // Input synchronizer and edge history
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (i_rst) begin
      rx_meta <= 1'b1;
      rx_s    <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= i_rx;
      rx_s    <= rx_meta;
      rx_prev <= rx_s;
    end
  end

  // ==========================================================================
  // Frame FSM
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (i_rst) begin
      state   <= uart_pkg::RX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= stop_sample;
      cnt     <= cnt + 1'b1;
      case (state)
        uart_pkg::RX_IDLE: begin
          cnt <= '0;
          // Falling edge marks a possible start bit
          if (rx_prev && !rx_s) begin
            state <= uart_pkg::RX_START;
          end
        end
        uart_pkg::RX_START: begin
          if (half_done) begin
            cnt     <= '0;
            bit_idx <= '0;
            // Glitch shorter than half a bit goes back to idle
            state   <= rx_s ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end
        end
        uart_pkg::RX_DATA: begin
          if (bit_done) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= uart_pkg::RX_STOP;
            end
          end
        end
        default: begin
          if (bit_done) begin
            state <= uart_pkg::RX_IDLE;
          end
        end
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if ((state == uart_pkg::RX_DATA) && bit_done) begin
      shift <= {rx_s, shift[7:1]};
    end
    if (stop_sample) begin
      o_word.data      <= shift;
      o_word.frame_err <= ~rx_s;
    end
  end

endmodule

// ==== source/uart_pkg.sv ====
// UART echo shared types: FSM state encodings and the received word
package uart_pkg;

  // Receiver FSM
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  // Transmitter FSM
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  // One deserialized frame as it travels through the FIFO
  typedef struct packed {
    logic [7:0] data;
    // Stop bit was sampled low
    logic       frame_err;
  } rx_word_t;

endpackage

// ==== source/uart_settings.svh ====
// UART echo sizing: serial bit period in clocks and FIFO depth
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Clocks per serial bit, the simulation speed-up divider
`define UART_CLKS_PER_BIT 8

// FIFO depth is 2**UART_FIFO_DEPTH_LOG2 received words
`define UART_FIFO_DEPTH_LOG2 3

`endif
